// ==== vlog.f ====
+incdir+source
source/cu_pkg.sv
source/opcode_decoder.sv
source/phase_sequencer.sv
source/control_encoder.sv
source/control_unit.sv
tb/control_unit_checker.sv
tb/control_unit_tb.sv

// ==== tb/control_unit_tb.sv ====
`timescale 1ns/1ps
`include "cu_config.svh"

module control_unit_tb;
    import cu_pkg::*;

    localparam int NUM_INSTR        = 300;
    localparam int CLK_PERIOD       = 4;
    localparam int MAX_INSTR_CYCLES = 17;
    localparam int TIMEOUT_NS       = (NUM_INSTR * MAX_INSTR_CYCLES + 100) * CLK_PERIOD;

    logic         clk;
    logic         reset;
    opcode_t      opcode;
    funct_t       funct;
    logic         ov;
    ctrl_word_t   ctrl;
    ctrl_word_t   exp_q[$];
    instr_class_t cls_exp;
    opcode_t      op_next;
    funct_t       fn_next;
    logic         ov_pick;
    string        name;
    int           cycles;
    int           ctrl_errors  = 0;
    int           cause_errors = 0;
    int           cycle_errors = 0;

    control_unit dut_i (
        .clk    (clk),
        .reset  (reset),
        .opcode (opcode),
        .funct  (funct),
        .ov     (ov),
        .ctrl   (ctrl)
    );

    bind control_unit control_unit_checker checker_i (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the control unit stopped issuing ir_write pulses");
        $display("Verification failed");
        $finish;
    end

    task automatic check_ctrl(input string tname, input int idx, input ctrl_word_t exp,
                              input ctrl_word_t act);
        if (act !== exp) begin
            ctrl_errors++;
            $display("** Error [%s] word %0d: expected %h, actual %h", tname, idx, exp, act);
        end
    endtask

    task automatic check_cause(input string tname, input exc_cause_t exp, input exc_cause_t act);
        if (act !== exp) begin
            cause_errors++;
            $display("** Error [%s] cause: expected %s, actual %s", tname, exp.name(), act.name());
        end
    endtask

    function automatic instr_class_t classify(input opcode_t op, input funct_t fn);
        if (op == `CU_OP_RTYPE) begin
            if (fn == `CU_FN_ADD) return CLS_ADD;
            if (fn == `CU_FN_SUB) return CLS_SUB;
            if (fn == `CU_FN_AND) return CLS_AND;
            return CLS_ILLEGAL;
        end
        if (op == `CU_OP_ADDI) return CLS_ADDI;
        if (op == `CU_OP_ADDIU) return CLS_ADDIU;
        if (op == `CU_OP_LW) return CLS_LW;
        if (op == `CU_OP_LH) return CLS_LH;
        if (op == `CU_OP_LB) return CLS_LB;
        return CLS_ILLEGAL;
    endfunction

    task automatic pick_instr(output opcode_t op, output funct_t fn);
        int kind;
        kind = $urandom_range(0, 9);
        fn   = funct_t'($urandom);
        case (kind)
            0, 1, 2, 8: op = `CU_OP_RTYPE;
            3:          op = `CU_OP_ADDI;
            4:          op = `CU_OP_ADDIU;
            5:          op = `CU_OP_LW;
            6:          op = `CU_OP_LH;
            7:          op = `CU_OP_LB;
            default: begin
                op = opcode_t'($urandom);
                while (op inside {`CU_OP_RTYPE, `CU_OP_ADDI, `CU_OP_ADDIU,
                                  `CU_OP_LW, `CU_OP_LH, `CU_OP_LB}) begin
                    op = op + 1'b1;
                end
            end
        endcase
        case (kind)
            0: fn = `CU_FN_ADD;
            1: fn = `CU_FN_SUB;
            2: fn = `CU_FN_AND;
            8: begin
                while (fn inside {`CU_FN_ADD, `CU_FN_SUB, `CU_FN_AND}) begin
                    fn = fn + 1'b1;
                end
            end
            default: ;
        endcase
    endtask

    function automatic ctrl_word_t fetch_word(input logic load);
        ctrl_word_t w;
        w           = '0;
        w.alu_src_b = SRCB_FOUR;
        w.alu_op    = ALU_ADD;
        w.pc_write  = load;
        w.ir_write  = load;
        return w;
    endfunction

    // Words from one ir_write pulse up to the cycle before the next one
    task automatic build_expect(input instr_class_t c, input logic ov_in);
        ctrl_word_t w;
        logic       rtype;
        logic       trap;
        rtype = c inside {CLS_ADD, CLS_SUB, CLS_AND};
        trap  = ov_in && (c inside {CLS_ADD, CLS_SUB, CLS_ADDI});
        exp_q.delete();
        exp_q.push_back(fetch_word(1'b1));
        w         = '0;
        w.a_write = 1'b1;
        w.b_write = 1'b1;
        exp_q.push_back(w);
        exp_q.push_back('0);
        if (c inside {CLS_LW, CLS_LH, CLS_LB}) begin
            w              = '0;
            w.alu_src_a    = SRCA_A;
            w.alu_src_b    = SRCB_IMM;
            w.alu_op       = ALU_ADD;
            w.aluout_write = 1'b1;
            exp_q.push_back(w);
            w          = '0;
            w.iord     = IORD_ALUOUT;
            w.mem_read = 1'b1;
            repeat (`CU_MEM_WAIT) exp_q.push_back(w);
            w           = '0;
            w.mdr_write = 1'b1;
            w.mdr_sel   = (c == CLS_LH) ? MDR_HALF : (c == CLS_LB) ? MDR_BYTE : MDR_WORD;
            exp_q.push_back(w);
            w            = '0;
            w.reg_write  = 1'b1;
            w.mem_to_reg = 1'b1;
            w.reg_dst    = DST_RT;
            exp_q.push_back(w);
        end else if (c != CLS_ILLEGAL) begin
            w              = '0;
            w.alu_src_a    = SRCA_A;
            w.alu_src_b    = rtype ? SRCB_B : SRCB_IMM;
            w.alu_op       = (c == CLS_SUB) ? ALU_SUB : (c == CLS_AND) ? ALU_AND : ALU_ADD;
            w.aluout_write = 1'b1;
            exp_q.push_back(w);
            if (!trap) begin
                w           = '0;
                w.reg_write = 1'b1;
                w.reg_dst   = rtype ? DST_RD : DST_RT;
                exp_q.push_back(w);
            end
        end
        if (c == CLS_ILLEGAL || trap) begin
            w       = '0;
            w.iord  = IORD_VECTOR;
            w.cause = trap ? EXC_OVERFLOW : EXC_NOOPCODE;
            // A trap turns the writeback cycle into an extra vector wait
            repeat (`CU_EXC_WAIT + int'(trap)) exp_q.push_back(w);
            w           = '0;
            w.epc_write = 1'b1;
            w.pc_write  = 1'b1;
            w.pc_src    = PCSRC_VECTOR;
            exp_q.push_back(w);
        end
        repeat (`CU_FETCH_WAIT) exp_q.push_back(fetch_word(1'b0));
    endtask

    initial begin
        void'($urandom(32'h0578_6f53));
        reset = 1'b1;
        ov    = 1'b0;
        pick_instr(op_next, fn_next);
        opcode = op_next;
        funct  = fn_next;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Zero word, then fetch waits until the first IR load
        cycles = 0;
        do begin
            @(posedge clk);
            if (!ctrl.ir_write) begin
                check_ctrl("reset release", cycles, (cycles == 0) ? '0 : fetch_word(1'b0), ctrl);
                cycles++;
            end
        end while (!ctrl.ir_write);
        if (cycles != `CU_FETCH_WAIT + 1) begin
            cycle_errors++;
            $display("First ir_write came %0d cycles after reset release instead of %0d",
                     cycles, `CU_FETCH_WAIT + 1);
        end

        for (int n = 0; n < NUM_INSTR; n++) begin
            // Opcode on the bus now is the one decoded in this cycle
            cls_exp = classify(opcode, funct);
            ov_pick = logic'($urandom_range(0, 1));
            build_expect(cls_exp, ov_pick);
            name = $sformatf("instr %0d %s ov=%0b", n, cls_exp.name(), ov_pick);
            pick_instr(op_next, fn_next);
            opcode <= op_next;
            funct  <= fn_next;
            ov     <= ov_pick;
            cycles = 0;
            do begin
                if (cycles < exp_q.size()) begin
                    check_ctrl(name, cycles, exp_q[cycles], ctrl);
                    if (exp_q[cycles].iord == IORD_VECTOR) begin
                        check_cause(name, exp_q[cycles].cause, ctrl.cause);
                    end
                end
                cycles++;
                @(posedge clk);
            end while (!ctrl.ir_write);
            if (cycles != exp_q.size()) begin
                cycle_errors++;
                $display("%s took %0d cycles between ir_write pulses instead of %0d",
                         name, cycles, exp_q.size());
            end
        end

        $display("Errors: ctrl %0d, cause %0d, cycle count %0d, assertion %0d",
                 ctrl_errors, cause_errors, cycle_errors, dut_i.checker_i.failures);
        if (ctrl_errors + cause_errors + cycle_errors + dut_i.checker_i.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== tb/control_unit_checker.sv ====
`timescale 1ns/1ps

module control_unit_checker (
    input logic               clk,
    input logic               reset,
    input cu_pkg::ctrl_word_t ctrl
);
    int unsigned failures = 0;

    // IR load always comes with the PC+4 update
    ir_with_pc: assert property (@(posedge clk) disable iff (reset)
        ctrl.ir_write |-> ctrl.pc_write)
        else begin
            $error("ir_write asserted without pc_write");
            failures++;
        end

    reg_epc_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ctrl.reg_write && ctrl.epc_write))
        else begin
            $error("reg_write and epc_write asserted in the same cycle");
            failures++;
        end

    // Zero shows one cycle after reset is sampled
    zero_in_reset: assert property (@(posedge clk) reset |=> ctrl == '0)
        else begin
            $error("ctrl word not zero during reset");
            failures++;
        end

endmodule

// ==== source/control_unit.sv ====
`timescale 1ns/1ps

module control_unit (
    input  logic               clk,
    input  logic               reset,
    input  cu_pkg::opcode_t    opcode,
    input  cu_pkg::funct_t     funct,
    input  logic               ov,
    output cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    cls_info_t cls;
    step_t     step;

    opcode_decoder decoder_i (
        .clk    (clk),
        .reset  (reset),
        .step   (step),
        .opcode (opcode),
        .funct  (funct),
        .cls    (cls)
    );

    phase_sequencer sequencer_i (
        .clk   (clk),
        .reset (reset),
        .cls   (cls),
        .ov    (ov),
        .step  (step)
    );

    control_encoder encoder_i (
        .clk   (clk),
        .reset (reset),
        .step  (step),
        .cls   (cls),
        .ctrl  (ctrl)
    );

endmodule

// ==== source/control_encoder.sv ====
`timescale 1ns/1ps

module control_encoder (
    input  logic               clk,
    input  logic               reset,
    input  cu_pkg::step_t      step,
    input  cu_pkg::cls_info_t  cls,
    output cu_pkg::ctrl_word_t ctrl
);
    import cu_pkg::*;

    ctrl_word_t ctrl_next;
    logic       is_rtype;
    alu_op_t    exec_op;

    assign is_rtype = cls.iclass inside {CLS_ADD, CLS_SUB, CLS_AND};

    always_comb begin
        case (cls.iclass)
            CLS_ADD, CLS_ADDI, CLS_ADDIU: exec_op = ALU_ADD;
            CLS_SUB:                      exec_op = ALU_SUB;
            CLS_AND:                      exec_op = ALU_AND;
            default:                      exec_op = ALU_PASS;
        endcase
    end

    always_comb begin
        ctrl_next = '0;
        case (step)
            STEP_FETCH_WAIT, STEP_FETCH_LOAD: begin
                // PC+4 held on the ALU output while IMEM settles
                ctrl_next.iord      = IORD_PC;
                ctrl_next.alu_src_a = SRCA_PC;
                ctrl_next.alu_src_b = SRCB_FOUR;
                ctrl_next.alu_op    = ALU_ADD;
                if (step == STEP_FETCH_LOAD) begin
                    ctrl_next.pc_write = 1'b1;
                    ctrl_next.ir_write = 1'b1;
                    ctrl_next.pc_src   = PCSRC_ALU;
                end
            end
            STEP_DECODE: begin
                ctrl_next.a_write = 1'b1;
                ctrl_next.b_write = 1'b1;
            end
            STEP_EXEC: begin
                ctrl_next.alu_src_a    = SRCA_A;
                ctrl_next.alu_src_b    = is_rtype ? SRCB_B : SRCB_IMM;
                ctrl_next.alu_op       = exec_op;
                ctrl_next.aluout_write = 1'b1;
            end
            STEP_WRITEBACK: begin
                ctrl_next.reg_write = 1'b1;
                ctrl_next.reg_dst   = is_rtype ? DST_RD : DST_RT;
            end
            STEP_ADDR: begin
                ctrl_next.alu_src_a    = SRCA_A;
                ctrl_next.alu_src_b    = SRCB_IMM;
                ctrl_next.alu_op       = ALU_ADD;
                ctrl_next.aluout_write = 1'b1;
            end
            STEP_MEM_WAIT: begin
                ctrl_next.iord     = IORD_ALUOUT;
                ctrl_next.mem_read = 1'b1;
            end
            STEP_MDR_SEL: begin
                ctrl_next.mdr_write = 1'b1;
                case (cls.iclass)
                    CLS_LH:  ctrl_next.mdr_sel = MDR_HALF;
                    CLS_LB:  ctrl_next.mdr_sel = MDR_BYTE;
                    default: ctrl_next.mdr_sel = MDR_WORD;
                endcase
            end
            STEP_LOAD_WB: begin
                ctrl_next.reg_write  = 1'b1;
                ctrl_next.mem_to_reg = 1'b1;
                ctrl_next.reg_dst    = DST_RT;
            end
            STEP_EXC_WAIT: begin
                ctrl_next.iord  = IORD_VECTOR;
                ctrl_next.cause = cls.traps_on_overflow ? EXC_OVERFLOW : EXC_NOOPCODE;
            end
            STEP_EXC_JUMP: begin
                ctrl_next.epc_write = 1'b1;
                ctrl_next.pc_write  = 1'b1;
                ctrl_next.pc_src    = PCSRC_VECTOR;
            end
            default: ctrl_next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else begin
            ctrl <= ctrl_next;
        end
    end

endmodule

// ==== source/phase_sequencer.sv ====
`timescale 1ns/1ps
`include "cu_config.svh"

module phase_sequencer (
    input  logic              clk,
    input  logic              reset,
    input  cu_pkg::cls_info_t cls,
    input  logic              ov,
    output cu_pkg::step_t     step
);
    import cu_pkg::*;

    localparam logic [`CU_CNT_W-1:0] FETCH_LAST = `CU_CNT_W'(`CU_FETCH_WAIT - 1);
    localparam logic [`CU_CNT_W-1:0] MEM_LAST   = `CU_CNT_W'(`CU_MEM_WAIT - 1);
    localparam logic [`CU_CNT_W-1:0] EXC_LAST   = `CU_CNT_W'(`CU_EXC_WAIT - 1);

    step_t                step_q;
    step_t                step_next;
    logic [`CU_CNT_W-1:0] cnt;
    logic [`CU_CNT_W-1:0] wait_last;
    logic                 in_wait;
    logic                 wait_done;
    logic                 trap;

    assign trap = (step_q == STEP_WRITEBACK) && ov && cls.traps_on_overflow;

    // A trapped overflow shows the vector wait straight away, so the
    // encoder never sees the writeback step and issues no register write
    assign step = trap ? STEP_EXC_WAIT : step_q;

    always_comb begin
        case (step_q)
            STEP_FETCH_WAIT: wait_last = FETCH_LAST;
            STEP_MEM_WAIT:   wait_last = MEM_LAST;
            default:         wait_last = EXC_LAST;
        endcase
    end

    assign in_wait   = step_q inside {STEP_FETCH_WAIT, STEP_MEM_WAIT, STEP_EXC_WAIT};
    assign wait_done = (cnt == wait_last);

    always_comb begin
        step_next = step_q;
        case (step_q)
            STEP_FETCH_WAIT: begin
                if (wait_done) begin
                    step_next = STEP_FETCH_LOAD;
                end
            end
            STEP_FETCH_LOAD: step_next = STEP_DECODE;
            STEP_DECODE:     step_next = STEP_DISPATCH;
            STEP_DISPATCH: begin
                case (cls.iclass)
                    CLS_LW, CLS_LH, CLS_LB: step_next = STEP_ADDR;
                    CLS_ILLEGAL:            step_next = STEP_EXC_WAIT;
                    default:                step_next = STEP_EXEC;
                endcase
            end
            STEP_EXEC:       step_next = STEP_WRITEBACK;
            STEP_WRITEBACK:  step_next = trap ? STEP_EXC_WAIT : STEP_FETCH_WAIT;
            STEP_ADDR:       step_next = STEP_MEM_WAIT;
            STEP_MEM_WAIT: begin
                if (wait_done) begin
                    step_next = STEP_MDR_SEL;
                end
            end
            STEP_MDR_SEL:    step_next = STEP_LOAD_WB;
            STEP_LOAD_WB:    step_next = STEP_FETCH_WAIT;
            STEP_EXC_WAIT: begin
                if (wait_done) begin
                    step_next = STEP_EXC_JUMP;
                end
            end
            STEP_EXC_JUMP:   step_next = STEP_FETCH_WAIT;
            default:         step_next = STEP_FETCH_WAIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            step_q <= STEP_FETCH_WAIT;
            cnt    <= '0;
        end else begin
            step_q <= step_next;
            // Counter is back at zero whenever a wait is entered
            if (in_wait && !wait_done) begin
                cnt <= cnt + 1'b1;
            end else begin
                cnt <= '0;
            end
        end
    end

endmodule

// ==== source/opcode_decoder.sv ====
`timescale 1ns/1ps
`include "cu_config.svh"

module opcode_decoder (
    input  logic              clk,
    input  logic              reset,
    input  cu_pkg::step_t     step,
    input  cu_pkg::opcode_t   opcode,
    input  cu_pkg::funct_t    funct,
    output cu_pkg::cls_info_t cls
);
    import cu_pkg::*;

    cls_info_t cls_next;

    always_comb begin
        cls_next.iclass = CLS_ILLEGAL;
        case (opcode)
            `CU_OP_RTYPE: begin
                case (funct)
                    `CU_FN_ADD: cls_next.iclass = CLS_ADD;
                    `CU_FN_SUB: cls_next.iclass = CLS_SUB;
                    `CU_FN_AND: cls_next.iclass = CLS_AND;
                    default:    cls_next.iclass = CLS_ILLEGAL;
                endcase
            end
            `CU_OP_ADDI:  cls_next.iclass = CLS_ADDI;
            `CU_OP_ADDIU: cls_next.iclass = CLS_ADDIU;
            `CU_OP_LW:    cls_next.iclass = CLS_LW;
            `CU_OP_LH:    cls_next.iclass = CLS_LH;
            `CU_OP_LB:    cls_next.iclass = CLS_LB;
            default:      cls_next.iclass = CLS_ILLEGAL;
        endcase

        // Only the signed adds trap on overflow
        cls_next.traps_on_overflow = cls_next.iclass inside {CLS_ADD, CLS_SUB, CLS_ADDI};
    end

    // IR is stable from here until the next fetch
    always_ff @(posedge clk) begin
        if (reset) begin
            cls.iclass            <= CLS_ILLEGAL;
            cls.traps_on_overflow <= 1'b0;
        end else if (step == STEP_DECODE) begin
            cls <= cls_next;
        end
    end

endmodule

// ==== source/cu_pkg.sv ====
`include "cu_config.svh"

package cu_pkg;

    typedef logic [`CU_OPCODE_W-1:0] opcode_t;
    typedef logic [`CU_FUNCT_W-1:0]  funct_t;

    typedef enum logic [3:0] {
        CLS_ADD, CLS_SUB, CLS_AND, CLS_ADDI, CLS_ADDIU,
        CLS_LW, CLS_LH, CLS_LB, CLS_ILLEGAL
    } instr_class_t;

    typedef enum logic [3:0] {
        STEP_FETCH_WAIT, STEP_FETCH_LOAD, STEP_DECODE, STEP_DISPATCH,
        STEP_EXEC, STEP_WRITEBACK,
        STEP_ADDR, STEP_MEM_WAIT, STEP_MDR_SEL, STEP_LOAD_WB,
        STEP_EXC_WAIT, STEP_EXC_JUMP
    } step_t;

    typedef enum logic [2:0] {ALU_NONE, ALU_ADD, ALU_AND, ALU_SUB, ALU_PASS} alu_op_t;
    typedef enum logic [1:0] {SRCA_PC, SRCA_A} alu_src_a_t;
    typedef enum logic [2:0] {SRCB_B, SRCB_FOUR, SRCB_IMM} alu_src_b_t;
    typedef enum logic [2:0] {IORD_PC, IORD_ALUOUT, IORD_VECTOR} iord_t;
    typedef enum logic [1:0] {MDR_WORD, MDR_HALF, MDR_BYTE} mdr_sel_t;
    typedef enum logic [1:0] {DST_RT, DST_RD} reg_dst_t;
    typedef enum logic [1:0] {PCSRC_ALU, PCSRC_VECTOR} pc_src_t;

    typedef enum logic [1:0] {
        EXC_NOOPCODE = 2'd0,
        EXC_OVERFLOW = 2'd1
    } exc_cause_t;

    // One control word per cycle to the datapath
    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       a_write;
        logic       b_write;
        logic       aluout_write;
        logic       mem_read;
        logic       mdr_write;
        logic       reg_write;
        logic       epc_write;
        reg_dst_t   reg_dst;
        logic       mem_to_reg;   // 1 selects MDR as register write data
        iord_t      iord;
        alu_src_a_t alu_src_a;
        alu_src_b_t alu_src_b;
        alu_op_t    alu_op;
        pc_src_t    pc_src;
        mdr_sel_t   mdr_sel;
        exc_cause_t cause;
    } ctrl_word_t;

    typedef struct packed {
        instr_class_t iclass;
        logic         traps_on_overflow;
    } cls_info_t;

endpackage

// ==== source/cu_config.svh ====
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

// Instruction field widths
`define CU_OPCODE_W 6
`define CU_FUNCT_W  6

// Opcodes
`define CU_OP_RTYPE 6'h00
`define CU_OP_ADDI  6'h08
`define CU_OP_ADDIU 6'h09
`define CU_OP_LW    6'h23
`define CU_OP_LH    6'h21
`define CU_OP_LB    6'h20

// R-type funct codes
`define CU_FN_ADD 6'h20
`define CU_FN_SUB 6'h22
`define CU_FN_AND 6'h24

// Instruction memory read latency
`define CU_FETCH_WAIT 3

// Data memory read latency
`define CU_MEM_WAIT 2

// Exception vector read latency
`define CU_EXC_WAIT 8

// Must hold the longest wait
`define CU_CNT_W 4

`endif
